// File: include/mv_macros.svh
`ifndef MV_MACROS_SVH
`define MV_MACROS_SVH

// Array shape.
`define MV_CORES 8
`define MV_DEPTH 128
`define MV_PAIR_AW 6

// Data path and host word.
`define MV_DW 32
`define MV_HOST_W 80

// Last element to final sum, in cycles.
`define MV_PIPE 3

`endif

// File: verilog/mv_pkg.sv
`include "mv_macros.svh"

package mv_pkg;

    typedef enum logic [1:0] {
        host_none   = 2'd0,
        host_weight = 2'd1,
        host_run    = 2'd2
    } host_kind_e;

    // Weight pair write, even weight above the odd one.
    typedef struct packed {
        host_kind_e                                                            kind;
        logic [`MV_HOST_W-3-$clog2(`MV_CORES)-`MV_PAIR_AW-2*`MV_DW:0]          pad;
        logic [$clog2(`MV_CORES)-1:0]                                          core;
        logic [`MV_PAIR_AW-1:0]                                                addr;
        logic [`MV_DW-1:0]                                                     even;
        logic [`MV_DW-1:0]                                                     odd;
    } host_wgt_s;

    typedef struct packed {
        host_kind_e                          kind;
        logic [`MV_HOST_W-4-$clog2(`MV_DEPTH):0] pad;
        logic [$clog2(`MV_DEPTH):0]          len;
    } host_cmd_s;

    // Kind sits in the top two bits of both views.
    typedef union packed {
        host_wgt_s wgt;
        host_cmd_s cmd;
    } host_word_u;

    typedef struct packed {
        logic [`MV_PAIR_AW-1:0] addr;
        logic [2*`MV_DW-1:0]    pair;
    } mat_wr_s;

    typedef struct packed {
        logic [$clog2(`MV_DEPTH)-1:0] idx;
        logic [`MV_DW-1:0]            data;
    } exec_s;

endpackage

// File: verilog/mv_host_decode.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_host_decode import mv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       host_v,
    input  host_word_u                 host_d,
    input  logic                       busy,
    output logic [`MV_CORES-1:0]       mat_v,
    output mat_wr_s                    mat_wr,
    output logic                       run_start,
    output logic [$clog2(`MV_DEPTH):0] run_len,
    output logic                       cmd_err
);

    logic host_ok;
    logic len_ok;

    // A run already issued counts as busy until the FSM catches up.
    assign host_ok = host_v && !busy && !run_start;
    assign len_ok  = (host_d.cmd.len != '0) && (host_d.cmd.len <= `MV_DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            mat_v     <= '0;
            run_start <= 1'b0;
            cmd_err   <= 1'b0;
        end else begin
            mat_v     <= '0;
            run_start <= 1'b0;
            cmd_err   <= 1'b0;
            if (host_ok) begin
                case (host_d.wgt.kind)
                    host_weight: mat_v <= `MV_CORES'(1) << host_d.wgt.core;
                    host_run: begin
                        if (len_ok)
                            run_start <= 1'b1;
                        else
                            cmd_err <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Payload for both views, qualified by the strobes above.
    always_ff @(posedge clk) begin
        if (host_v) begin
            mat_wr.addr <= host_d.wgt.addr;
            mat_wr.pair <= {host_d.wgt.odd, host_d.wgt.even};
            run_len     <= host_d.cmd.len;
        end
    end

endmodule

// File: verilog/mv_seq_fsm.sv
`timescale 1ns/1ps

module mv_seq_fsm (
    input  logic clk,
    input  logic reset,
    input  logic run_start,
    input  logic vec_v,
    input  logic last_elem,
    input  logic timer_done,
    output logic busy,
    output logic init,
    output logic exec,
    output logic update,
    output logic out_period,
    output logic result_v,
    output logic cnt_clear,
    output logic cnt_step,
    output logic timer_load,
    output logic timer_sel
);

    localparam logic [1:0] s_idle   = 2'd0;
    localparam logic [1:0] s_run    = 2'd1;
    localparam logic [1:0] s_drain  = 2'd2;
    localparam logic [1:0] s_unload = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;

    assign busy       = (state != s_idle);
    assign exec       = (state == s_run) && vec_v;
    assign cnt_step   = exec;
    assign cnt_clear  = (state == s_idle) && run_start;
    assign out_period = (state == s_unload);
    assign result_v   = out_period;

    // Drain count starts on the last element, unload count on the update cycle.
    assign timer_load = (exec && last_elem) || update;
    assign timer_sel  = (state == s_unload);

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (run_start)
                    state_nxt = s_run;
            end
            s_run: begin
                if (exec && last_elem)
                    state_nxt = s_drain;
            end
            s_drain: begin
                if (timer_done)
                    state_nxt = s_unload;
            end
            s_unload: begin
                if (timer_done && !update)
                    state_nxt = s_idle;
            end
            default: state_nxt = s_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= s_idle;
            init   <= 1'b0;
            update <= 1'b0;
        end else begin
            state  <= state_nxt;
            init   <= cnt_clear;
            // First unload cycle. Final sums are settled by now.
            update <= (state == s_drain) && timer_done;
        end
    end

endmodule

// File: verilog/mv_step_counter.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_step_counter import mv_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cnt_clear,
    input  logic                       cnt_step,
    input  logic [$clog2(`MV_DEPTH):0] run_len,
    input  logic [`MV_DW-1:0]          vec_d,
    input  logic                       timer_load,
    input  logic                       timer_sel,
    output exec_s                      exec_info,
    output logic                       last_elem,
    output logic                       timer_done
);

    localparam int tw = $clog2(`MV_CORES) + 1;

    logic [$clog2(`MV_DEPTH)-1:0] idx;
    logic [$clog2(`MV_DEPTH):0]   len;
    logic [tw-1:0]                timer;

    assign exec_info.idx  = idx;
    assign exec_info.data = vec_d;
    assign last_elem      = ({1'b0, idx} == len - 1'b1);

    // Load cycle is the first of the counted cycles.
    assign timer_done = (timer == tw'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            idx <= '0;
        end else if (cnt_clear) begin
            idx <= '0;
        end else if (cnt_step) begin
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_clear)
            len <= run_len;
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer <= '0;
        else if (timer_load)
            timer <= timer_sel ? tw'(`MV_CORES - 1) : tw'(`MV_PIPE - 1);
        else if (timer != '0)
            timer <= timer - 1'b1;
    end

endmodule

// File: verilog/mv_core.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_core import mv_pkg::*; (
    input  logic              clk,
    input  logic              init,
    input  logic              mat_v,
    input  mat_wr_s           mat_wr,
    input  logic              exec,
    input  exec_s             exec_info,
    input  logic              update,
    input  logic              out_period,
    input  logic [`MV_DW-1:0] acc_next,
    output logic [`MV_DW-1:0] acc
);

    // One row, split by index parity.
    logic [`MV_DW-1:0] bank_even [0:`MV_DEPTH/2-1];
    logic [`MV_DW-1:0] bank_odd  [0:`MV_DEPTH/2-1];

    logic [`MV_DW-1:0] rd_even;
    logic [`MV_DW-1:0] rd_odd;
    logic [`MV_DW-1:0] src_d1;
    logic              odd_d1;
    logic [`MV_DW-1:0] m2;
    logic [`MV_DW-1:0] d2;
    logic [`MV_DW-1:0] product;
    logic [`MV_DW-1:0] acc_left;
    logic [`MV_DW-1:0] acc_right;
    logic              init_d1;
    logic              init_d2;
    logic              exec_d1;
    logic              exec_d2;

    always_ff @(posedge clk) begin
        if (mat_v)
            bank_even[mat_wr.addr] <= mat_wr.pair[`MV_DW-1:0];
        if (exec)
            rd_even <= bank_even[exec_info.idx[$clog2(`MV_DEPTH)-1:1]];
    end

    always_ff @(posedge clk) begin
        if (mat_v)
            bank_odd[mat_wr.addr] <= mat_wr.pair[2*`MV_DW-1:`MV_DW];
        if (exec)
            rd_odd <= bank_odd[exec_info.idx[$clog2(`MV_DEPTH)-1:1]];
    end

    always_ff @(posedge clk) begin
        if (exec) begin
            odd_d1 <= exec_info.idx[0];
            src_d1 <= exec_info.data;
        end
    end

    // init and exec see the same two-stage delay.
    always_ff @(posedge clk) begin
        init_d1 <= init;
        init_d2 <= init_d1;
        exec_d1 <= exec;
        exec_d2 <= exec_d1;
    end

    // Operand register ahead of the multiplier.
    always_ff @(posedge clk) begin
        if (exec_d1) begin
            m2 <= odd_d1 ? rd_odd : rd_even;
            d2 <= src_d1;
        end
    end

    assign product = m2 * d2;

    always_ff @(posedge clk) begin
        // Clear and first product may land on the same edge.
        if (init_d2)
            acc_left <= exec_d2 ? product : '0;
        else if (exec_d2)
            acc_left <= acc_left + product;
    end

    always_ff @(posedge clk) begin
        if (out_period)
            acc_right <= acc_next;
    end

    // Local sum on update, shift chain after that.
    assign acc = update ? acc_left : acc_right;

endmodule

// File: verilog/mv_array_top.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_array_top import mv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              host_v,
    input  host_word_u        host_d,
    input  logic              vec_v,
    input  logic [`MV_DW-1:0] vec_d,
    output logic              busy,
    output logic              cmd_err,
    output logic              result_v,
    output logic [`MV_DW-1:0] result_d
);

    logic [`MV_CORES-1:0]       mat_v;
    mat_wr_s                    mat_wr;
    logic                       run_start;
    logic [$clog2(`MV_DEPTH):0] run_len;
    logic                       init;
    logic                       exec;
    logic                       update;
    logic                       out_period;
    logic                       cnt_clear;
    logic                       cnt_step;
    logic                       timer_load;
    logic                       timer_sel;
    logic                       last_elem;
    logic                       timer_done;
    exec_s                      exec_info;

    // Result chain, one extra slot for the zero fill.
    logic [`MV_DW-1:0]          chain [0:`MV_CORES];

    mv_host_decode i_decode (
        .clk       (clk),
        .reset     (reset),
        .host_v    (host_v),
        .host_d    (host_d),
        .busy      (busy),
        .mat_v     (mat_v),
        .mat_wr    (mat_wr),
        .run_start (run_start),
        .run_len   (run_len),
        .cmd_err   (cmd_err)
    );

    mv_seq_fsm i_fsm (
        .clk        (clk),
        .reset      (reset),
        .run_start  (run_start),
        .vec_v      (vec_v),
        .last_elem  (last_elem),
        .timer_done (timer_done),
        .busy       (busy),
        .init       (init),
        .exec       (exec),
        .update     (update),
        .out_period (out_period),
        .result_v   (result_v),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .timer_load (timer_load),
        .timer_sel  (timer_sel)
    );

    mv_step_counter i_counter (
        .clk        (clk),
        .reset      (reset),
        .cnt_clear  (cnt_clear),
        .cnt_step   (cnt_step),
        .run_len    (run_len),
        .vec_d      (vec_d),
        .timer_load (timer_load),
        .timer_sel  (timer_sel),
        .exec_info  (exec_info),
        .last_elem  (last_elem),
        .timer_done (timer_done)
    );

    assign chain[`MV_CORES] = '0;

    for (genvar k = 0; k < `MV_CORES; k++) begin : g_core
        mv_core i_core (
            .clk        (clk),
            .init       (init),
            .mat_v      (mat_v[k]),
            .mat_wr     (mat_wr),
            .exec       (exec),
            .exec_info  (exec_info),
            .update     (update),
            .out_period (out_period),
            .acc_next   (chain[k+1]),
            .acc        (chain[k])
        );
    end

    // Rows leave through core 0.
    assign result_d = chain[0];

endmodule

// File: tb/mv_properties.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_properties (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic cmd_err,
    input logic result_v,
    input logic update,
    input logic exec,
    input logic last_elem
);

    // Eight result cycles, then the bus goes quiet.
    property p_result_burst;
        @(posedge clk) disable iff (reset)
            $rose(result_v) |=> result_v ##1 result_v ##1 result_v ##1 result_v
                ##1 result_v ##1 result_v ##1 result_v ##1 !result_v;
    endproperty

    // Update sits in the burst, a fixed drain after the last element.
    property p_update_in_burst;
        @(posedge clk) disable iff (reset)
            update |-> result_v && $past(exec && last_elem, `MV_PIPE);
    endproperty

    property p_err_not_on_start;
        @(posedge clk) disable iff (reset) !(cmd_err && $rose(busy));
    endproperty

    a_result_burst: assert property (p_result_burst)
        else $error("result_v burst is not eight cycles long");

    a_update_in_burst: assert property (p_update_in_burst)
        else $error("update outside the result burst or off the drain timing");

    a_err_not_on_start: assert property (p_err_not_on_start)
        else $error("cmd_err coincides with busy rising");

endmodule

bind mv_array_top mv_properties i_props (
    .clk       (clk),
    .reset     (reset),
    .busy      (busy),
    .cmd_err   (cmd_err),
    .result_v  (result_v),
    .update    (update),
    .exec      (exec),
    .last_elem (last_elem)
);

// File: tb/mv_tb.sv
`timescale 1ns/1ps
`include "mv_macros.svh"

module mv_tb import mv_pkg::*; ();

    typedef struct packed {
        logic [7:0] len;
        logic       gap;
        logic [1:0] wload;
        logic       new_vec;
        logic       noise;
        logic       exp_err;
    } case_s;

    localparam int n_cases    = 10;
    localparam int wait_limit = 400;

    // Columns are len, gap, wload, new_vec, noise, exp_err.
    // wload 0 keeps the matrix, 1 reloads all of it, 2 rewrites one pair.
    case_s cases [0:n_cases-1] = '{
        '{8'd128, 1'b0, 2'd1, 1'b1, 1'b0, 1'b0},
        '{8'd1,   1'b0, 2'd0, 1'b1, 1'b0, 1'b0},
        '{8'd3,   1'b0, 2'd0, 1'b0, 1'b0, 1'b0},
        '{8'd128, 1'b0, 2'd0, 1'b1, 1'b0, 1'b0},
        '{8'd128, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0},
        '{8'd0,   1'b0, 2'd0, 1'b0, 1'b0, 1'b1},
        '{8'd200, 1'b0, 2'd0, 1'b0, 1'b0, 1'b1},
        '{8'd96,  1'b1, 2'd0, 1'b1, 1'b1, 1'b0},
        '{8'd128, 1'b0, 2'd2, 1'b0, 1'b0, 1'b0},
        '{8'd7,   1'b1, 2'd1, 1'b1, 1'b0, 1'b0}
    };

    logic              clk;
    logic              reset;
    logic              host_v;
    host_word_u        host_d;
    logic              vec_v;
    logic [`MV_DW-1:0] vec_d;
    logic              busy;
    logic              cmd_err;
    logic              result_v;
    logic [`MV_DW-1:0] result_d;

    // Model copies of the matrix and the vector.
    logic [`MV_DW-1:0] wmem [0:`MV_CORES-1][0:`MV_DEPTH-1];
    logic [`MV_DW-1:0] vec  [0:`MV_DEPTH-1];
    int                value_errs;
    int                timeout_errs;

    mv_array_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .host_v   (host_v),
        .host_d   (host_d),
        .vec_v    (vec_v),
        .vec_d    (vec_d),
        .busy     (busy),
        .cmd_err  (cmd_err),
        .result_v (result_v),
        .result_d (result_d)
    );

    always #10 clk = ~clk;

    task automatic check_result(input int row, input logic [`MV_DW-1:0] got,
                                input logic [`MV_DW-1:0] exp);
        if (got !== exp) begin
            $display("Fail result_d row %0d: got %h, expected %h", row, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    // Wrapped sum of weight times element below the run length.
    function automatic logic [`MV_DW-1:0] row_sum(input int row, input int len);
        logic [`MV_DW-1:0] sum;
        sum = '0;
        for (int i = 0; i < len; i++)
            sum = sum + wmem[row][i] * vec[i];
        return sum;
    endfunction

    function automatic logic probe(input string name);
        if (name == "busy")
            return busy;
        else if (name == "result_v")
            return result_v;
        return cmd_err;
    endfunction

    function automatic host_word_u weight_word(input int core, input int pair,
                                               input logic [`MV_DW-1:0] even,
                                               input logic [`MV_DW-1:0] odd);
        host_word_u w;
        w          = '0;
        w.wgt.kind = host_weight;
        w.wgt.core = core[$clog2(`MV_CORES)-1:0];
        w.wgt.addr = pair[`MV_PAIR_AW-1:0];
        w.wgt.even = even;
        w.wgt.odd  = odd;
        return w;
    endfunction

    task automatic write_pair(input int core, input int pair);
        logic [`MV_DW-1:0] even;
        logic [`MV_DW-1:0] odd;
        even                 = $urandom;
        odd                  = $urandom;
        wmem[core][2*pair]   = even;
        wmem[core][2*pair+1] = odd;
        host_v               = 1'b1;
        host_d               = weight_word(core, pair, even, odd);
        @(negedge clk);
        host_v = 1'b0;
    endtask

    task automatic send_run(input int len);
        host_word_u w;
        w          = '0;
        w.cmd.kind = host_run;
        w.cmd.len  = len[7:0];
        host_v     = 1'b1;
        host_d     = w;
        @(negedge clk);
        host_v = 1'b0;
    endtask

    // Polls at the falling edge until the named output goes high.
    task automatic wait_high(input string name, output int cycles);
        cycles = 0;
        while (probe(name) !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (probe(name) !== 1'b1) begin
            $display("Timed out waiting for %s to go high", name);
            timeout_errs++;
        end
    endtask

    task automatic stream_vector(input int len, input logic gap, input logic noise);
        for (int i = 0; i < len; i++) begin
            if (gap) begin
                repeat ($urandom % 3) begin
                    vec_v = 1'b0;
                    vec_d = $urandom;
                    @(negedge clk);
                end
            end
            vec_v  = 1'b1;
            vec_d  = vec[i];
            // A weight word halfway through must be dropped.
            // It targets the last pair, which this run has yet to read.
            host_v = noise && (i == len / 2);
            host_d = weight_word(0, (len - 1) / 2, $urandom, $urandom);
            @(negedge clk);
            host_v = 1'b0;
        end
        vec_v = 1'b0;
    endtask

    task automatic collect_results(input int len);
        int cycles;
        wait_high("result_v", cycles);
        if (result_v !== 1'b1)
            return;
        // Polling starts one cycle after the last element.
        check_count("result latency", cycles + 1, `MV_PIPE);
        for (int r = 0; r < `MV_CORES; r++) begin
            check_flag("result_v", result_v, 1'b1);
            check_result(r, result_d, row_sum(r, len));
            @(negedge clk);
        end
        check_flag("result_v", result_v, 1'b0);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic check_rejected();
        int cycles;
        wait_high("cmd_err", cycles);
        check_flag("busy", busy, 1'b0);
        repeat (12) begin
            @(negedge clk);
            check_flag("cmd_err", cmd_err, 1'b0);
            check_flag("busy", busy, 1'b0);
            check_flag("result_v", result_v, 1'b0);
        end
    endtask

    initial begin
        case_s tc;
        int    cycles;
        void'($urandom(59));
        clk          = 1'b0;
        reset        = 1'b1;
        host_v       = 1'b0;
        host_d       = '0;
        vec_v        = 1'b0;
        vec_d        = '0;
        value_errs   = 0;
        timeout_errs = 0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("result_v", result_v, 1'b0);
        check_flag("cmd_err", cmd_err, 1'b0);

        for (int c = 0; c < n_cases; c++) begin
            tc = cases[c];
            if (tc.wload == 2'd1) begin
                for (int k = 0; k < `MV_CORES; k++)
                    for (int p = 0; p < `MV_DEPTH / 2; p++)
                        write_pair(k, p);
            end else if (tc.wload == 2'd2) begin
                write_pair($urandom % `MV_CORES, $urandom % (`MV_DEPTH / 2));
            end
            if (tc.new_vec) begin
                for (int i = 0; i < `MV_DEPTH; i++)
                    vec[i] = $urandom;
            end
            // Idle strobes must not advance the element index.
            if (tc.noise) begin
                repeat (4) begin
                    vec_v = 1'b1;
                    vec_d = $urandom;
                    @(negedge clk);
                end
                vec_v = 1'b0;
            end
            send_run(tc.len);
            if (tc.exp_err) begin
                check_rejected();
            end else begin
                wait_high("busy", cycles);
                check_count("busy latency", cycles, 1);
                check_flag("cmd_err", cmd_err, 1'b0);
                stream_vector(tc.len, tc.gap, tc.noise);
                collect_results(tc.len);
            end
            repeat (2) @(negedge clk);
        end

        $display("Errors: %0d value, %0d timeout", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: project.f
+incdir+include
verilog/mv_pkg.sv
verilog/mv_host_decode.sv
verilog/mv_seq_fsm.sv
verilog/mv_step_counter.sv
verilog/mv_core.sv
verilog/mv_array_top.sv
tb/mv_properties.sv
tb/mv_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := mv_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
